// ==== Bender.yml ====
package:
  name: compute_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/compute_isa_pkg.sv
      - hw/compute_data_pkg.sv
      - hw/stage_if.sv
      - hw/issue_control.sv
      - hw/memory_access.sv
      - hw/coeff_store.sv
      - hw/mac_array.sv
      - hw/accumulator_unit.sv
      - hw/compute_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/compute_properties.sv
      - testbench/compute_tb.sv

// ==== hw/accumulator_unit.sv ====
/* Two accumulators with MACC update, shift and saturation for stores */

`timescale 1ns/1ps

module accumulator_unit import compute_isa_pkg::*, compute_data_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	stage_if.accum    stage,
	input  sum_t      sum0,
	input  sum_t      sum1,
	output mem_word_t store_bytes,
	output byte_en_t  store_lanes
);

	acc_t acc0;
	acc_t acc1;
	acc_t base0;
	acc_t base1;
	logic macc_en;
	logic macc_zero;
	sat_t sat0;
	sat_t sat1;

	// Arithmetic shift, then clamp to a signed byte
	function automatic sat_t saturate(acc_t value, caddr_t shift);
		acc_t shifted;
		shifted = value >>> shift;
		if (&shifted[31:7] == |shifted[31:7])
			return shifted[7:0];
		return shifted[31] ? 8'h80 : 8'h7f;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Accumulate

	// MACCZ has bit 1 set in its opcode
	assign base0 = macc_zero ? acc_t'(0) : acc0;
	assign base1 = macc_zero ? acc_t'(0) : acc1;

	always_ff @(posedge clock) begin
		if (reset) begin
			macc_en <= 1'b0;
			macc_zero <= 1'b0;
			acc0 <= '0;
			acc1 <= '0;
		end else begin
			// Decoded a cycle early, while the products are ready
			macc_en <= stage.mac_strobe && stage.mac_op == OP_MACC;
			macc_zero <= stage.mac_mode[1];
			if (macc_en) begin
				acc0 <= base0 + acc_t'(sum0);
				acc1 <= base1 + acc_t'(sum1);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Store data

	always_ff @(posedge clock) begin
		if (stage.accum_strobe && stage.accum_op == OP_STORE) begin
			sat0 <= saturate(acc0, stage.accum_caddr);
			sat1 <= saturate(acc1, stage.accum_caddr);
		end
	end

	assign store_bytes = {48'b0, sat1, sat0};

	// Store0 keeps lane 0, Store1 keeps lane 1
	assign store_lanes = (stage.wb_strobe && stage.wb_op == OP_STORE)
		? {6'b0, !stage.wb_mode[0], !stage.wb_mode[1]} : 8'b0;

endmodule

// ==== hw/coeff_store.sv ====
/* Coefficient RAM with its base pointer, loads and registered readout */

`timescale 1ns/1ps
`include "compute_consts.svh"

module coeff_store import compute_isa_pkg::*, compute_data_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	stage_if.coeff    stage,
	input  mem_word_t mem_rdata,
	output coeff_t    coeff
);

	coeff_t coeff_mem [`COEFF_DEPTH];
	caddr_t cbp;
	caddr_t read_addr;
	logic   load_pending;
	logic   load_low;
	caddr_t load_addr;

	// Nine bit sum wraps around the table
	assign read_addr = stage.coeff_caddr + cbp;

	always_ff @(posedge clock) begin
		coeff <= coeff_mem[read_addr];
		load_low <= stage.coeff_mode[0];
		load_addr <= stage.coeff_caddr;
		// Read data arrives one cycle after the coeff stage
		if (load_pending) begin
			if (load_low)
				coeff_mem[load_addr][63:0] <= mem_rdata;
			else
				coeff_mem[load_addr][127:64] <= mem_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cbp <= '0;
			load_pending <= 1'b0;
		end else begin
			load_pending <= stage.coeff_strobe && stage.coeff_op == OP_LOAD_COEFF;
			if (stage.coeff_strobe && stage.coeff_op == OP_CBP)
				cbp <= stage.coeff_caddr + (stage.coeff_mode[0] ? cbp : '0);
		end
	end

endmodule

// ==== hw/compute_consts.svh ====
/* Depths, lane count, latencies and pipeline stage numbers */

`ifndef COMPUTE_CONSTS_SVH
`define COMPUTE_CONSTS_SVH

`define COEFF_DEPTH   512
`define LANES         8
`define MUL_LATENCY   3
`define READ_LATENCY  2

// Stage numbers count cycles after issue
`define STAGE_FETCH   1
`define STAGE_COEFF   (`STAGE_FETCH + `READ_LATENCY - 1)
`define STAGE_MAC     (`STAGE_FETCH + `READ_LATENCY + `MUL_LATENCY)
`define STAGE_ACCUM   (`STAGE_MAC + 1)
`define STAGE_WB      (`STAGE_ACCUM + 1)

`define PIPE_DEPTH    `STAGE_WB
`define WRITE_SLOT    `STAGE_WB

`endif

// ==== hw/compute_data_pkg.sv ====
/* Datapath widths: memory words, coefficients, sums and accumulators */

package compute_data_pkg;

	typedef logic [63:0] mem_word_t;
	typedef logic [15:0] mem_addr_t;
	typedef logic [7:0]  byte_en_t;

	// Low half feeds acc0, high half feeds acc1
	typedef logic [127:0] coeff_t;

	typedef logic signed [31:0] acc_t;

	// Eight 16 bit products fit in 19 bits
	typedef logic signed [19:0] sum_t;

	typedef logic [7:0] sat_t;

endpackage

// ==== hw/compute_isa_pkg.sv ====
/* Instruction field types, opcode encodings and decoded operations */

package compute_isa_pkg;

	typedef logic [31:0] insn_t;

	// Memory byte address field, also VBP and SBP
	typedef logic [16:0] maddr_t;

	// Coefficient address or shift field, also CBP
	typedef logic [8:0] caddr_t;

	typedef enum logic [5:0] {
		OPC_LOAD_COEFF0 = 6'd5,
		OPC_LOAD_COEFF1 = 6'd6,
		OPC_SET_VBP     = 6'd8,
		OPC_ADD_VBP     = 6'd9,
		OPC_SET_SBP     = 6'd12,
		OPC_ADD_SBP     = 6'd13,
		OPC_SET_CBP     = 6'd14,
		OPC_ADD_CBP     = 6'd15,
		OPC_STORE       = 6'd16,
		OPC_STORE0      = 6'd17,
		OPC_STORE1      = 6'd18,
		OPC_MACC        = 6'd40,
		OPC_MACCZ       = 6'd42
	} opcode_t;

	// Operation class carried down the pipeline
	typedef enum logic [2:0] {
		OP_NOP,
		OP_VBP,
		OP_CBP,
		OP_SBP,
		OP_LOAD_COEFF,
		OP_MACC,
		OP_STORE
	} op_t;

endpackage

// ==== hw/compute_top.sv ====
/* Top level of the MAC core, control and datapath wiring */

`timescale 1ns/1ps

module compute_top import compute_isa_pkg::*, compute_data_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	output logic      busy,
	input  logic      cmd_valid,
	output logic      cmd_ready,
	input  insn_t     cmd_insn,
	output logic      mem_ren,
	output byte_en_t  mem_wen,
	output mem_addr_t mem_addr,
	output mem_word_t mem_wdata,
	input  mem_word_t mem_rdata
);

	coeff_t    coeff;
	sum_t      sum0;
	sum_t      sum1;
	mem_word_t store_bytes;
	byte_en_t  store_lanes;

	stage_if stage ();

	issue_control u_issue_control (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_insn  (cmd_insn),
		.cmd_ready (cmd_ready),
		.busy      (busy),
		.stage     (stage.control)
	);

	memory_access u_memory_access (
		.clock       (clock),
		.reset       (reset),
		.stage       (stage.fetch),
		.store_bytes (store_bytes),
		.store_lanes (store_lanes),
		.mem_ren     (mem_ren),
		.mem_wen     (mem_wen),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata)
	);

	coeff_store u_coeff_store (
		.clock     (clock),
		.reset     (reset),
		.stage     (stage.coeff),
		.mem_rdata (mem_rdata),
		.coeff     (coeff)
	);

	// Read data and coefficient meet here in the same cycle
	mac_array u_mac_array (
		.clock (clock),
		.data  (mem_rdata),
		.coeff (coeff),
		.sum0  (sum0),
		.sum1  (sum1)
	);

	accumulator_unit u_accumulator_unit (
		.clock       (clock),
		.reset       (reset),
		.stage       (stage.accum),
		.sum0        (sum0),
		.sum1        (sum1),
		.store_bytes (store_bytes),
		.store_lanes (store_lanes)
	);

endmodule

// ==== hw/issue_control.sv ====
/* Command issue stage, opcode decode, memory port interlock
   and the in-order instruction pipeline */

`timescale 1ns/1ps
`include "compute_consts.svh"

module issue_control import compute_isa_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     cmd_valid,
	input  insn_t    cmd_insn,
	output logic     cmd_ready,
	output logic     busy,
	stage_if.control stage
);

	logic       s1_valid;
	insn_t      s1_insn;
	op_t        s1_op;
	logic       stall;

	logic [`PIPE_DEPTH-1:0] reserve;
	logic [`PIPE_DEPTH-1:0] need;

	logic [`PIPE_DEPTH:1] pipe_valid;
	op_t                  pipe_op    [1:`PIPE_DEPTH];
	logic [1:0]           pipe_mode  [1:`PIPE_DEPTH];
	maddr_t               pipe_maddr [1:`PIPE_DEPTH];
	caddr_t               pipe_caddr [1:`PIPE_DEPTH];

	//////////////////////////////////////////////////////////////////////
	// Issue stage

	always_comb begin
		case (s1_insn[5:0])
			OPC_SET_VBP, OPC_ADD_VBP:         s1_op = OP_VBP;
			OPC_SET_CBP, OPC_ADD_CBP:         s1_op = OP_CBP;
			OPC_SET_SBP, OPC_ADD_SBP:         s1_op = OP_SBP;
			OPC_LOAD_COEFF0, OPC_LOAD_COEFF1: s1_op = OP_LOAD_COEFF;
			OPC_MACC, OPC_MACCZ:              s1_op = OP_MACC;
			OPC_STORE, OPC_STORE0, OPC_STORE1: s1_op = OP_STORE;
			default:                          s1_op = OP_NOP;
		endcase
	end

	// Port slot wanted, counted from the cycle after issue
	always_comb begin
		need = '0;
		case (s1_op)
			OP_MACC, OP_LOAD_COEFF: need[0] = 1'b1;
			OP_STORE:               need[`WRITE_SLOT - 1] = 1'b1;
			default:                need = '0;
		endcase
		if (!s1_valid)
			need = '0;
	end

	assign stall = |(reserve & need);
	assign cmd_ready = !stall;
	assign busy = s1_valid || (|pipe_valid);

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
			reserve <= '0;
			pipe_valid <= '0;
		end else begin
			if (!stall)
				s1_valid <= cmd_valid;
			reserve <= (reserve | (stall ? '0 : need)) >> 1;
			pipe_valid <= {pipe_valid[`PIPE_DEPTH-1:1], s1_valid && !stall};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Pipeline payload

	always_ff @(posedge clock) begin
		if (!stall)
			s1_insn <= cmd_insn;
		pipe_op[1] <= s1_op;
		pipe_mode[1] <= s1_insn[1:0];
		pipe_maddr[1] <= s1_insn[31:15];
		pipe_caddr[1] <= s1_insn[14:6];
		for (int i = 2; i <= `PIPE_DEPTH; i++) begin
			pipe_op[i] <= pipe_op[i-1];
			pipe_mode[i] <= pipe_mode[i-1];
			pipe_maddr[i] <= pipe_maddr[i-1];
			pipe_caddr[i] <= pipe_caddr[i-1];
		end
	end

	assign stage.fetch_strobe = pipe_valid[`STAGE_FETCH];
	assign stage.fetch_op     = pipe_op[`STAGE_FETCH];
	assign stage.fetch_mode   = pipe_mode[`STAGE_FETCH];
	assign stage.fetch_maddr  = pipe_maddr[`STAGE_FETCH];

	assign stage.coeff_strobe = pipe_valid[`STAGE_COEFF];
	assign stage.coeff_op     = pipe_op[`STAGE_COEFF];
	assign stage.coeff_mode   = pipe_mode[`STAGE_COEFF];
	assign stage.coeff_caddr  = pipe_caddr[`STAGE_COEFF];

	assign stage.mac_strobe   = pipe_valid[`STAGE_MAC];
	assign stage.mac_op       = pipe_op[`STAGE_MAC];
	assign stage.mac_mode     = pipe_mode[`STAGE_MAC];

	assign stage.accum_strobe = pipe_valid[`STAGE_ACCUM];
	assign stage.accum_op     = pipe_op[`STAGE_ACCUM];
	assign stage.accum_caddr  = pipe_caddr[`STAGE_ACCUM];

	assign stage.wb_strobe    = pipe_valid[`STAGE_WB];
	assign stage.wb_op        = pipe_op[`STAGE_WB];
	assign stage.wb_mode      = pipe_mode[`STAGE_WB];
	assign stage.wb_maddr     = pipe_maddr[`STAGE_WB];

endmodule

// ==== hw/mac_array.sv ====
/* Pipelined signed byte multipliers and the two registered lane-sum
   adder trees */

`timescale 1ns/1ps
`include "compute_consts.svh"

module mac_array import compute_data_pkg::*; (
	input  logic      clock,
	input  mem_word_t data,
	input  coeff_t    coeff,
	output sum_t      sum0,
	output sum_t      sum1
);

	logic signed [15:0] product [2*`LANES];
	sum_t tree0;
	sum_t tree1;

	//////////////////////////////////////////////////////////////////////
	// Multipliers, first LANES feed acc0 and the rest acc1

	for (genvar m = 0; m < 2*`LANES; m++) begin : g_mul
		logic signed [7:0]  a;
		logic signed [7:0]  b;
		logic signed [15:0] pipe [`MUL_LATENCY];

		// Each data byte meets both coefficient halves
		assign a = data[8*(m % `LANES) +: 8];
		assign b = coeff[8*m +: 8];

		always_ff @(posedge clock) begin
			pipe[0] <= a * b;
			for (int k = 1; k < `MUL_LATENCY; k++)
				pipe[k] <= pipe[k-1];
		end

		assign product[m] = pipe[`MUL_LATENCY-1];
	end

	//////////////////////////////////////////////////////////////////////
	// Adder trees

	always_comb begin
		tree0 = '0;
		tree1 = '0;
		for (int l = 0; l < `LANES; l++) begin
			tree0 = tree0 + product[l];
			tree1 = tree1 + product[`LANES + l];
		end
	end

	always_ff @(posedge clock) begin
		sum0 <= tree0;
		sum1 <= tree1;
	end

endmodule

// ==== hw/memory_access.sv ====
/* Vector and store base pointers, address forming and the shared
   memory port */

`timescale 1ns/1ps

module memory_access import compute_isa_pkg::*, compute_data_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	stage_if.fetch    stage,
	input  mem_word_t store_bytes,
	input  byte_en_t  store_lanes,
	output logic      mem_ren,
	output byte_en_t  mem_wen,
	output mem_addr_t mem_addr,
	output mem_word_t mem_wdata
);

	maddr_t    vbp;
	maddr_t    sbp;
	maddr_t    read_byte;
	maddr_t    write_byte;
	mem_addr_t read_addr;
	mem_addr_t write_addr;

	//////////////////////////////////////////////////////////////////////
	// Read side, fetch stage

	// LoadCoeff addresses are absolute
	assign read_byte = (stage.fetch_op == OP_MACC) ? stage.fetch_maddr + vbp
		: stage.fetch_maddr;
	assign read_addr = read_byte[16:1];

	assign mem_ren = stage.fetch_strobe &&
		(stage.fetch_op == OP_MACC || stage.fetch_op == OP_LOAD_COEFF);

	//////////////////////////////////////////////////////////////////////
	// Write side, writeback stage

	assign write_byte = stage.wb_maddr + sbp;
	assign write_addr = write_byte[16:1];

	// Odd byte address moves the pair up one lane
	always_comb begin
		if (write_byte[0]) begin
			mem_wen = store_lanes << 1;
			mem_wdata = store_bytes << 8;
		end else begin
			mem_wen = store_lanes;
			mem_wdata = store_bytes;
		end
	end

	assign mem_addr = mem_ren ? read_addr : write_addr;

	always_ff @(posedge clock) begin
		if (reset) begin
			vbp <= '0;
			sbp <= '0;
		end else begin
			if (stage.fetch_strobe && stage.fetch_op == OP_VBP)
				vbp <= stage.fetch_maddr + (stage.fetch_mode[0] ? vbp : '0);
			if (stage.wb_strobe && stage.wb_op == OP_SBP)
				sbp <= stage.wb_maddr + (stage.wb_mode[0] ? sbp : '0);
		end
	end

endmodule

// ==== hw/stage_if.sv ====
/* Stage strobes and decoded fields from control to the datapath */

`timescale 1ns/1ps

interface stage_if import compute_isa_pkg::*; ();

	// Mode is the low two opcode bits
	logic       fetch_strobe;
	op_t        fetch_op;
	logic [1:0] fetch_mode;
	maddr_t     fetch_maddr;

	logic       coeff_strobe;
	op_t        coeff_op;
	logic [1:0] coeff_mode;
	caddr_t     coeff_caddr;

	logic       mac_strobe;
	op_t        mac_op;
	logic [1:0] mac_mode;

	logic       accum_strobe;
	op_t        accum_op;
	caddr_t     accum_caddr;

	logic       wb_strobe;
	op_t        wb_op;
	logic [1:0] wb_mode;
	maddr_t     wb_maddr;

	modport control (
		output fetch_strobe, fetch_op, fetch_mode, fetch_maddr,
		output coeff_strobe, coeff_op, coeff_mode, coeff_caddr,
		output mac_strobe, mac_op, mac_mode,
		output accum_strobe, accum_op, accum_caddr,
		output wb_strobe, wb_op, wb_mode, wb_maddr
	);

	modport fetch (
		input fetch_strobe, fetch_op, fetch_mode, fetch_maddr,
		input wb_strobe, wb_op, wb_mode, wb_maddr
	);

	modport coeff (input coeff_strobe, coeff_op, coeff_mode, coeff_caddr);

	modport accum (
		input mac_strobe, mac_op, mac_mode,
		input accum_strobe, accum_op, accum_caddr,
		input wb_strobe, wb_op, wb_mode
	);

endinterface

// ==== testbench/compute_properties.sv ====
/* Concurrent checks on the memory port and busy, bound to compute_top */

`timescale 1ns/1ps

module compute_properties import compute_data_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     busy,
	input logic     mem_ren,
	input byte_en_t mem_wen
);

	int violations = 0;

	// Lowest enabled lane
	byte_en_t low_lane;

	assign low_lane = mem_wen & (~mem_wen + 8'd1);

	property no_read_write_overlap;
		@(posedge clock) disable iff (reset)
			!(mem_ren && mem_wen != '0);
	endproperty

	property idle_after_reset;
		@(posedge clock) reset |=> !busy;
	endproperty

	// One lane, or two neighbouring lanes
	property lanes_adjacent;
		@(posedge clock) disable iff (reset)
			mem_wen != '0 |-> (mem_wen == low_lane || mem_wen == (low_lane | (low_lane << 1)));
	endproperty

	assert property (no_read_write_overlap) else begin
		violations++;
		$error("Memory read and write active in the same cycle");
	end

	assert property (idle_after_reset) else begin
		violations++;
		$error("busy high in the cycle after reset");
	end

	assert property (lanes_adjacent) else begin
		violations++;
		$error("Write enables are not a single lane or an adjacent pair");
	end

endmodule

bind compute_top compute_properties u_properties (
	.clock   (clock),
	.reset   (reset),
	.busy    (busy),
	.mem_ren (mem_ren),
	.mem_wen (mem_wen)
);

// ==== testbench/compute_tb.sv ====
/* Testbench for the MAC core with clock, reset, memory model, stimulus,
   reference model and memory checker */

`timescale 1ns/1ps
`include "compute_consts.svh"

module compute_tb import compute_isa_pkg::*, compute_data_pkg::*; ();

	localparam int TIMEOUT = 100;
	localparam int MEM_WORDS = 65536;

	logic      clock;
	logic      reset;
	logic      busy;
	logic      cmd_valid;
	logic      cmd_ready;
	insn_t     cmd_insn;
	logic      mem_ren;
	byte_en_t  mem_wen;
	mem_addr_t mem_addr;
	mem_word_t mem_wdata;
	mem_word_t mem_rdata;

	mem_word_t mem     [MEM_WORDS];
	mem_word_t exp_mem [MEM_WORDS];
	mem_addr_t rd_addr [`READ_LATENCY];
	logic [`READ_LATENCY-1:0] rd_valid;

	// Reference state updated in command order
	maddr_t ref_vbp;
	maddr_t ref_sbp;
	caddr_t ref_cbp;
	int     ref_acc0;
	int     ref_acc1;
	coeff_t ref_coeff [`COEFF_DEPTH];

	integer seed;
	int     stall_cycles;
	logic   check_request;

	compute_top dut (
		.clock     (clock),
		.reset     (reset),
		.busy      (busy),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_insn  (cmd_insn),
		.mem_ren   (mem_ren),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	always #4 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Memory model

	always @(posedge clock) begin
		rd_valid <= {rd_valid[`READ_LATENCY-2:0], mem_ren};
		rd_addr[0] <= mem_addr;
		for (int k = 1; k < `READ_LATENCY; k++)
			rd_addr[k] <= rd_addr[k-1];
		for (int b = 0; b < `LANES; b++)
			if (mem_wen[b])
				mem[mem_addr][8*b +: 8] <= mem_wdata[8*b +: 8];
	end

	assign mem_rdata = rd_valid[`READ_LATENCY-1] ? mem[rd_addr[`READ_LATENCY-1]] : '0;

	// Every word depends on all address bits
	function automatic mem_word_t fill_word(int addr);
		logic [15:0] a;
		a = addr[15:0];
		return {a ^ 16'h5a3c, ~a, {a[7:0], a[15:8]}, a * 16'd2653};
	endfunction

	function automatic insn_t make_insn(logic [5:0] opcode, logic [8:0] caddr,
		logic [16:0] maddr);
		return {maddr, caddr, opcode};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [7:0] clamp_byte(int value, logic [8:0] shift);
		int shifted;
		if (shift >= 32)
			shifted = (value < 0) ? -1 : 0;
		else
			shifted = value >>> shift;
		if (shifted > 127)
			return 8'h7f;
		if (shifted < -128)
			return 8'h80;
		return shifted[7:0];
	endfunction

	function automatic void execute_ref(insn_t insn);
		logic [5:0]        opc;
		logic [8:0]        caddr;
		logic [16:0]       maddr;
		logic [16:0]       byte_addr;
		logic [8:0]        idx;
		mem_word_t         data;
		coeff_t            entry;
		logic signed [7:0] d;
		logic signed [7:0] c0;
		logic signed [7:0] c1;
		int                sum0;
		int                sum1;
		int                pos;
		opc = insn[5:0];
		caddr = insn[14:6];
		maddr = insn[31:15];
		case (opc)
			OPC_SET_VBP:     ref_vbp = maddr;
			OPC_ADD_VBP:     ref_vbp = ref_vbp + maddr;
			OPC_SET_SBP:     ref_sbp = maddr;
			OPC_ADD_SBP:     ref_sbp = ref_sbp + maddr;
			OPC_SET_CBP:     ref_cbp = caddr;
			OPC_ADD_CBP:     ref_cbp = ref_cbp + caddr;
			OPC_LOAD_COEFF0: ref_coeff[caddr][63:0] = exp_mem[maddr[16:1]];
			OPC_LOAD_COEFF1: ref_coeff[caddr][127:64] = exp_mem[maddr[16:1]];
			OPC_MACC, OPC_MACCZ: begin
				byte_addr = maddr + ref_vbp;
				data = exp_mem[byte_addr[16:1]];
				idx = caddr + ref_cbp;
				entry = ref_coeff[idx];
				sum0 = 0;
				sum1 = 0;
				for (int l = 0; l < `LANES; l++) begin
					d = data[8*l +: 8];
					c0 = entry[8*l +: 8];
					c1 = entry[64 + 8*l +: 8];
					sum0 += d * c0;
					sum1 += d * c1;
				end
				ref_acc0 = (opc == OPC_MACCZ) ? sum0 : ref_acc0 + sum0;
				ref_acc1 = (opc == OPC_MACCZ) ? sum1 : ref_acc1 + sum1;
			end
			OPC_STORE, OPC_STORE0, OPC_STORE1: begin
				byte_addr = maddr + ref_sbp;
				pos = byte_addr[0];
				if (opc != OPC_STORE1)
					exp_mem[byte_addr[16:1]][8*pos +: 8] = clamp_byte(ref_acc0, caddr);
				if (opc != OPC_STORE0)
					exp_mem[byte_addr[16:1]][8*pos + 8 +: 8] = clamp_byte(ref_acc1, caddr);
			end
			default: ;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checking

	task automatic fail_run();
		$display("Errors found");
		$fatal(1, "Stopped at the first error");
	endtask

	// Whole memory against the reference image
	always @(posedge clock) begin
		if (check_request) begin
			for (int i = 0; i < MEM_WORDS; i++) begin
				assert (mem[i] === exp_mem[i]) else begin
					$display("Fail at %0d ns: mem[%0h] is %h, expected %h",
						$time, i, mem[i], exp_mem[i]);
					fail_run();
				end
			end
			check_request = 1'b0;
		end
	end

	always @(posedge clock) begin
		assert (dut.u_properties.violations == 0) else begin
			$display("A bound assertion on compute_top failed");
			fail_run();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks

	task automatic send_cmd(insn_t insn);
		int waited;
		waited = 0;
		cmd_valid = 1'b1;
		cmd_insn = insn;
		while (!cmd_ready) begin
			stall_cycles++;
			@(posedge clock);
			#1;
			waited++;
			if (waited > TIMEOUT) begin
				$display("Command %h was not accepted in time", insn);
				fail_run();
			end
		end
		@(posedge clock);
		#1;
		execute_ref(insn);
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		cmd_valid = 1'b0;
		while (busy) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > TIMEOUT) begin
				$display("busy did not fall in time");
				fail_run();
			end
		end
	endtask

	task automatic check_memory();
		int waited;
		waited = 0;
		check_request = 1'b1;
		while (check_request) begin
			@(posedge clock);
			#1;
			waited++;
			if (waited > TIMEOUT) begin
				$display("Memory comparison did not complete");
				fail_run();
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Programs

	initial begin
		seed = 32'h8b4e_cd4f;
		stall_cycles = 0;
		clock = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		check_request = 1'b0;
		rd_valid = '0;
		ref_vbp = '0;
		ref_sbp = '0;
		ref_cbp = '0;
		ref_acc0 = 0;
		ref_acc1 = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = fill_word(i);
			exp_mem[i] = mem[i];
		end
		// Read region with random vectors and coefficients
		for (int i = 0; i < 256; i++) begin
			mem[i] = {$random(seed), $random(seed)};
			exp_mem[i] = mem[i];
		end
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		assert (busy === 1'b0) else begin
			$display("Fail at %0d ns: busy is %b, expected 0", $time, busy);
			fail_run();
		end
		assert (cmd_ready === 1'b1) else begin
			$display("Fail at %0d ns: cmd_ready is %b, expected 1", $time, cmd_ready);
			fail_run();
		end
		send_cmd(make_insn(OPC_SET_VBP, 9'd0, 17'd0));
		send_cmd(make_insn(OPC_SET_CBP, 9'd0, 17'd0));
		send_cmd(make_insn(OPC_SET_SBP, 9'd0, 17'h10000));
		send_cmd(make_insn(OPC_STORE, 9'd0, 17'h24));
		wait_idle();
		check_memory();

		// Entries 0 to 31 from words 128 to 191
		for (int e = 0; e < 32; e++) begin
			send_cmd(make_insn(OPC_LOAD_COEFF0, 9'(e), 17'(256 + 4*e)));
			send_cmd(make_insn(OPC_LOAD_COEFF1, 9'(e), 17'(258 + 4*e)));
		end
		wait_idle();
		// VBP near the top so the read address wraps
		send_cmd(make_insn(OPC_SET_VBP, 9'd0, 17'h1fe00));
		for (int r = 0; r < 4; r++) begin
			send_cmd(make_insn(OPC_MACCZ, 9'($random(seed) & 31),
				17'h200 + 17'(2 * ($random(seed) & 63))));
			send_cmd(make_insn(OPC_STORE, 9'd0, 17'(8'h30 + 2*r)));
		end
		wait_idle();
		check_memory();

		send_cmd(make_insn(OPC_SET_VBP, 9'd0, 17'd0));
		send_cmd(make_insn(OPC_SET_CBP, 9'd0, 17'd0));
		send_cmd(make_insn(OPC_MACCZ, 9'd0, 17'd0));
		for (int k = 0; k < 6; k++) begin
			send_cmd(make_insn(OPC_MACC, 9'($random(seed) & 7), 17'($random(seed) & 255)));
			send_cmd(make_insn(OPC_ADD_VBP, 9'd0, 17'd8));
			send_cmd(make_insn(OPC_ADD_CBP, 9'd2, 17'd0));
		end
		send_cmd(make_insn(OPC_STORE, 9'($random(seed) & 15), 17'h40));
		send_cmd(make_insn(OPC_STORE, 9'd40, 17'h42));
		wait_idle();
		check_memory();

		// Single lane stores at odd and even byte addresses
		send_cmd(make_insn(OPC_SET_SBP, 9'd0, 17'h10101));
		for (int k = 0; k < 8; k++)
			send_cmd(make_insn(((k / 2) % 2) ? OPC_STORE1 : OPC_STORE0,
				9'($random(seed) & 7), 17'(5*k)));
		wait_idle();
		check_memory();

		// Back to back stream where a MACC seven slots after a Store stalls
		stall_cycles = 0;
		send_cmd(make_insn(OPC_SET_VBP, 9'd0, 17'd0));
		send_cmd(make_insn(OPC_SET_CBP, 9'd0, 17'd0));
		send_cmd(make_insn(OPC_SET_SBP, 9'd0, 17'h12000));
		for (int r = 0; r < 3; r++) begin
			send_cmd(make_insn(OPC_STORE, 9'($random(seed) & 7), 17'(4*r)));
			for (int k = 0; k < 7; k++)
				send_cmd(make_insn((k == 0) ? OPC_MACCZ : OPC_MACC,
					9'($random(seed) & 15), 17'($random(seed) & 511)));
		end
		send_cmd(make_insn(OPC_STORE, 9'd3, 17'd12));
		wait_idle();
		check_memory();
		assert (stall_cycles > 0) else begin
			$display("cmd_ready never dropped during the back to back stream");
			fail_run();
		end

		if (dut.u_properties.violations == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("A bound assertion on compute_top failed");
			fail_run();
		end
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/compute_isa_pkg.sv
hw/compute_data_pkg.sv
hw/stage_if.sv
hw/issue_control.sv
hw/memory_access.sv
hw/coeff_store.sv
hw/mac_array.sv
hw/accumulator_unit.sv
hw/compute_top.sv
testbench/compute_properties.sv
testbench/compute_tb.sv
